// ==== common/accel_num_pkg.sv ====
`default_nettype none

package accel_num_pkg;

    localparam int half_w   = 16;
    localparam int word_w   = 32;
    localparam int win3_len = 9;   // Elements in a 3x3 window

    // IEEE 754 binary16 operand
    typedef logic [half_w-1:0] half_t;

    // FIFO word, low half is the first operand
    typedef logic [word_w-1:0] word_t;

    // 1x1 window holds a single operand
    typedef half_t win1_t;

    // 3x3 window, element 0 sits in the lowest bits
    typedef half_t [win3_len-1:0] win3_t;

endpackage

`default_nettype wire

// ==== common/accel_cmd_pkg.sv ====
`default_nettype none

package accel_cmd_pkg;

    // Operation codes seen in command word 0
    typedef enum logic [7:0] {
        op_conv1x1 = 8'd1,
        op_conv3x3 = 8'd2
    } op_e;

    localparam int cmd_words  = 5;
    localparam int cmd_cnt_w  = $clog2(cmd_words);

    // Word positions inside one command
    localparam int word_hdr    = 0;   // Op and stride
    localparam int word_chan   = 1;   // Input and output channel counts
    localparam int word_weight = 2;
    localparam int word_data   = 3;
    localparam int word_wb     = 4;

    typedef struct packed {
        op_e         op;
        logic [7:0]  stride;
        logic [15:0] out_ch;
        logic [15:0] in_ch;
        logic [31:0] weight_addr;
        logic [31:0] data_addr;
        logic [31:0] wb_addr;
    } cmd_t;

    // True for the codes the sequencer can run
    function automatic logic op_valid(input logic [7:0] code);
        return (code == op_conv1x1) || (code == op_conv3x3);
    endfunction

endpackage

`default_nettype wire

// ==== design/cmd_decoder.sv ====
`default_nettype none

module cmd_decoder
    import accel_num_pkg::*;
    import accel_cmd_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  op_en,
    input  logic  busy,
    input  word_t cmd_word,
    input  logic  cmd_fifo_empty,
    output logic  cmd_fifo_rd_en,
    output logic  cmd_valid,
    output cmd_t  cmd
);

    logic [cmd_cnt_w-1:0] word_cnt;
    logic                 last_word;

    // Hold off while a command is issued or running
    assign cmd_fifo_rd_en = op_en && !cmd_fifo_empty && !busy && !cmd_valid;
    assign last_word      = cmd_fifo_rd_en && (word_cnt == cmd_cnt_w'(cmd_words - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            word_cnt <= '0;
        end else if (cmd_fifo_rd_en) begin
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;
        end
    end

    // Op field captured with word 0 is checked on the last word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= last_word && op_valid(cmd.op);
        end
    end

    // Fields only change on a read and stay put while busy
    always_ff @(posedge clk) begin
        if (cmd_fifo_rd_en) begin
            case (word_cnt)
                word_hdr: begin
                    cmd.op     <= op_e'(cmd_word[7:0]);
                    cmd.stride <= cmd_word[15:8];
                end
                word_chan: begin
                    cmd.in_ch  <= cmd_word[15:0];
                    cmd.out_ch <= cmd_word[31:16];
                end
                word_weight: cmd.weight_addr <= cmd_word;
                word_data:   cmd.data_addr   <= cmd_word;
                word_wb:     cmd.wb_addr     <= cmd_word;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/operand_packer.sv ====
`default_nettype none

module operand_packer
    import accel_num_pkg::*;
#(
    parameter type payload_t = win1_t
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     start,
    input  word_t    fifo_word,
    input  logic     fifo_empty,
    output logic     rd_en,
    output logic     done,
    output payload_t payload
);

    localparam int halves = $bits(payload_t) / $bits(half_t);
    localparam int cnt_w  = $clog2(halves + 2);

    logic                   active;
    logic [cnt_w-1:0]       half_idx;   // Element filled by the low half
    logic                   last_rd;
    half_t [halves-1:0]     buf_q;

    assign rd_en   = active && !fifo_empty;   // Stall on empty
    assign last_rd = rd_en && ((32'(half_idx) + 2) >= halves);
    assign payload = payload_t'(buf_q);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            half_idx <= '0;
            done     <= 1'b0;
        end else begin
            done <= last_rd;
            if (start) begin
                active   <= 1'b1;
                half_idx <= '0;
            end else if (rd_en) begin
                half_idx <= half_idx + cnt_w'(2);
                if (last_rd) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // Two halves per word, an odd tail drops the upper half
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < halves; i++) begin
                if (i == 32'(half_idx)) begin
                    buf_q[i] <= fifo_word[15:0];
                end else if (i == 32'(half_idx) + 1) begin
                    buf_q[i] <= fifo_word[31:16];
                end
            end
        end
    end

    // Sequencer must not restart a window still being filled
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n)
        start |-> !active
    );

endmodule

`default_nettype wire

// ==== design/addr_gen.sv ====
`default_nettype none

module addr_gen
    import accel_cmd_pkg::*;
#(
    parameter int addr_w = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  cmd_t              cmd,
    input  logic              win_step,
    input  logic              chan_step,
    input  logic              chan_restart,
    output logic [addr_w-1:0] r_addr,
    output logic [addr_w-1:0] w_addr
);

    logic [addr_w-1:0] data_base;
    logic [addr_w-1:0] stride_inc;

    assign data_base  = addr_w'(cmd.data_addr);
    assign stride_inc = addr_w'(cmd.stride);   // Zero extended

    // Read side walks the input channels of one output channel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            r_addr <= '0;
        end else if (cmd_valid || chan_restart) begin
            r_addr <= data_base;
        end else if (win_step) begin
            r_addr <= r_addr + stride_inc;
        end
    end

    // One write-back slot per output channel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_addr <= '0;
        end else if (cmd_valid) begin
            w_addr <= addr_w'(cmd.wb_addr);
        end else if (chan_step) begin
            w_addr <= w_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== csb/csb_sequencer.sv ====
`default_nettype none

module csb_sequencer
    import accel_num_pkg::*;
    import accel_cmd_pkg::*;
#(
    parameter int addr_w = 32
) (
    input  logic  clk,
    input  logic  arst_n,
    input  logic  cmd_valid,
    input  cmd_t  cmd,
    input  logic  data_1x1_done,
    input  logic  data_3x3_done,
    input  logic  weight_1x1_done,
    input  logic  weight_3x3_done,
    input  logic  data_1x1_rd_en,
    input  logic  data_3x3_rd_en,
    input  logic  weight_1x1_rd_en,
    input  logic  weight_3x3_rd_en,
    input  word_t weight_word,
    input  logic  data_fifo_empty,
    input  logic  weight_fifo_empty,
    input  logic  conv_valid_1x1,
    input  logic  conv_valid_3x3,
    output logic  busy,
    output logic  data_fifo_rd_en,
    output logic  weight_fifo_rd_en,
    output logic  data_1x1_start,
    output logic  data_3x3_start,
    output logic  weight_1x1_start,
    output logic  weight_3x3_start,
    output logic  win_step,
    output logic  chan_step,
    output logic  chan_restart,
    output half_t ib_1x1,
    output half_t ib_3x3,
    output logic  conv_ready_1x1,
    output logic  conv_ready_3x3,
    output logic  dma_aux_re,
    output logic  dma_aux_we,
    output logic  irq
);

    typedef enum logic [2:0] {st_idle, st_bias, st_load, st_ready, st_wb} state_e;

    state_e      state;
    logic        is_3x3;
    logic        start_q;
    logic        data_seen;
    logic        weight_seen;
    logic        data_ok;
    logic        weight_ok;
    logic        win_loaded;
    logic        bias_rd;
    logic        unit_valid;
    logic        last_in;
    logic        last_out;
    logic [15:0] in_idx;
    logic [15:0] out_idx;
    half_t       bias_q;

    assign busy       = (state != st_idle);
    assign bias_rd    = (state == st_bias) && !weight_fifo_empty;
    assign data_ok    = data_seen || data_1x1_done || data_3x3_done;
    assign weight_ok  = weight_seen || weight_1x1_done || weight_3x3_done;
    assign win_loaded = (state == st_load) && data_ok && weight_ok;
    assign unit_valid = (state == st_ready) && (is_3x3 ? conv_valid_3x3 : conv_valid_1x1);
    assign last_in    = (in_idx == cmd.in_ch - 16'd1);
    assign last_out   = (out_idx == cmd.out_ch - 16'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_idle;
            is_3x3  <= 1'b0;
            start_q <= 1'b0;
            in_idx  <= '0;
            out_idx <= '0;
        end else begin
            start_q <= 1'b0;
            case (state)
                st_idle: if (cmd_valid) begin
                    state   <= st_bias;
                    is_3x3  <= (cmd.op == op_conv3x3);
                    in_idx  <= '0;
                    out_idx <= '0;
                end
                st_bias: if (bias_rd) begin
                    state   <= st_load;
                    start_q <= 1'b1;               // First window of this channel
                end
                st_load: if (win_loaded) state <= st_ready;
                st_ready: if (unit_valid) begin
                    if (last_in) begin
                        state  <= st_wb;
                        in_idx <= '0;
                    end else begin
                        state   <= st_load;
                        start_q <= 1'b1;
                        in_idx  <= in_idx + 16'd1;
                    end
                end
                st_wb: if (last_out) begin
                    state <= st_idle;
                end else begin
                    state   <= st_bias;
                    out_idx <= out_idx + 16'd1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Packer done pulses may land in different cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            data_seen   <= 1'b0;
            weight_seen <= 1'b0;
        end else if (win_loaded) begin
            data_seen   <= 1'b0;
            weight_seen <= 1'b0;
        end else begin
            data_seen   <= data_ok;
            weight_seen <= weight_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (bias_rd) begin
            bias_q <= weight_word[15:0];   // Upper half unused
        end
    end

    assign data_1x1_start   = start_q && !is_3x3;
    assign weight_1x1_start = start_q && !is_3x3;
    assign data_3x3_start   = start_q && is_3x3;
    assign weight_3x3_start = start_q && is_3x3;

    assign data_fifo_rd_en   = data_1x1_rd_en || data_3x3_rd_en;
    assign weight_fifo_rd_en = bias_rd || weight_1x1_rd_en || weight_3x3_rd_en;

    assign conv_ready_1x1 = (state == st_ready) && !is_3x3;
    assign conv_ready_3x3 = (state == st_ready) && is_3x3;
    assign ib_1x1         = bias_q;
    assign ib_3x3         = bias_q;

    assign win_step     = unit_valid && !last_in;
    assign chan_restart = unit_valid && last_in;
    assign dma_aux_re   = start_q;
    assign dma_aux_we   = (state == st_wb);
    assign chan_step    = dma_aux_we;
    assign irq          = dma_aux_we && last_out;   // With the final write-back

    a_valid_1x1: assert property (
        @(posedge clk) disable iff (!arst_n)
        conv_valid_1x1 |-> conv_ready_1x1
    );

    a_valid_3x3: assert property (
        @(posedge clk) disable iff (!arst_n)
        conv_valid_3x3 |-> conv_ready_3x3
    );

    // Packers and bias read share these FIFOs
    a_data_rd: assert property (
        @(posedge clk) disable iff (!arst_n)
        data_fifo_rd_en |-> !data_fifo_empty
    );

    a_weight_rd: assert property (
        @(posedge clk) disable iff (!arst_n)
        weight_fifo_rd_en |-> !weight_fifo_empty
    );

endmodule

`default_nettype wire

// ==== csb/csb.sv ====
`default_nettype none

module csb
    import accel_num_pkg::*;
    import accel_cmd_pkg::*;
#(
    parameter int addr_w = 32
) (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              op_en,
    input  word_t             cmd,
    input  logic              cmd_fifo_empty,
    input  word_t             data,
    input  logic              data_fifo_empty,
    input  word_t             weightbias,
    input  logic              weight_fifo_empty,
    input  logic              conv_valid_1x1,
    input  logic              conv_valid_3x3,
    output logic              cmd_fifo_rd_en,
    output logic              data_fifo_rd_en,
    output logic              weight_fifo_rd_en,
    output win1_t             im_1x1,
    output win1_t             iw_1x1,
    output win3_t             im_3x3,
    output win3_t             iw_3x3,
    output half_t             ib_1x1,
    output half_t             ib_3x3,
    output logic              conv_ready_1x1,
    output logic              conv_ready_3x3,
    output logic              dma_aux_re,
    output logic              dma_aux_we,
    output logic [addr_w-1:0] r_addr,
    output logic [addr_w-1:0] w_addr,
    output logic              irq
);

    cmd_t cmd_dec;
    logic cmd_valid, busy;
    logic win_step, chan_step, chan_restart;
    logic d1_start, d3_start, w1_start, w3_start;
    logic d1_done, d3_done, w1_done, w3_done;
    logic d1_rd, d3_rd, w1_rd, w3_rd;

    cmd_decoder u_dec (
        .clk, .arst_n, .op_en, .busy,
        .cmd_word (cmd), .cmd_fifo_empty, .cmd_fifo_rd_en,
        .cmd_valid, .cmd (cmd_dec)
    );

    // Data and weight packers for both window sizes
    operand_packer #(.payload_t(win1_t)) u_data_1x1 (
        .clk, .arst_n, .start (d1_start), .fifo_word (data), .fifo_empty (data_fifo_empty),
        .rd_en (d1_rd), .done (d1_done), .payload (im_1x1)
    );
    operand_packer #(.payload_t(win3_t)) u_data_3x3 (
        .clk, .arst_n, .start (d3_start), .fifo_word (data), .fifo_empty (data_fifo_empty),
        .rd_en (d3_rd), .done (d3_done), .payload (im_3x3)
    );
    operand_packer #(.payload_t(win1_t)) u_weight_1x1 (
        .clk, .arst_n, .start (w1_start), .fifo_word (weightbias),
        .fifo_empty (weight_fifo_empty), .rd_en (w1_rd), .done (w1_done), .payload (iw_1x1)
    );
    operand_packer #(.payload_t(win3_t)) u_weight_3x3 (
        .clk, .arst_n, .start (w3_start), .fifo_word (weightbias),
        .fifo_empty (weight_fifo_empty), .rd_en (w3_rd), .done (w3_done), .payload (iw_3x3)
    );

    addr_gen #(.addr_w(addr_w)) u_addr (
        .clk, .arst_n, .cmd_valid, .cmd (cmd_dec),
        .win_step, .chan_step, .chan_restart, .r_addr, .w_addr
    );

    csb_sequencer #(.addr_w(addr_w)) u_seq (
        .clk, .arst_n, .cmd_valid, .cmd (cmd_dec),
        .data_1x1_done (d1_done), .data_3x3_done (d3_done),
        .weight_1x1_done (w1_done), .weight_3x3_done (w3_done),
        .data_1x1_rd_en (d1_rd), .data_3x3_rd_en (d3_rd),
        .weight_1x1_rd_en (w1_rd), .weight_3x3_rd_en (w3_rd),
        .weight_word (weightbias), .data_fifo_empty, .weight_fifo_empty,
        .conv_valid_1x1, .conv_valid_3x3,
        .busy, .data_fifo_rd_en, .weight_fifo_rd_en,
        .data_1x1_start (d1_start), .data_3x3_start (d3_start),
        .weight_1x1_start (w1_start), .weight_3x3_start (w3_start),
        .win_step, .chan_step, .chan_restart, .ib_1x1, .ib_3x3,
        .conv_ready_1x1, .conv_ready_3x3, .dma_aux_re, .dma_aux_we, .irq
    );

endmodule

`default_nettype wire

// ==== dv/csb_checks.svh ====
`ifndef csb_checks_svh
`define csb_checks_svh

logic [31:0] lfsr_state = 32'd39;

// Galois form, one shift per bit handed out
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int k = 0; k < n; k++) begin
        fb         = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (fb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
        end
        r = {r[30:0], fb};
    end
    return r;
endfunction

task automatic fail_with(input string why);
    $display("%s", why);
    stop_on_failure();
endtask

task automatic check_win1(input string name, input win1_t exp, input win1_t act);
    if (act !== exp) begin
        $display("mismatch %s expected %h actual %h", name, exp, act);
        stop_on_failure();
    end
endtask

task automatic check_win3(input string name, input win3_t exp, input win3_t act);
    if (act !== exp) begin
        $display("mismatch %s expected %h actual %h", name, exp, act);
        stop_on_failure();
    end
endtask

task automatic check_bias(input string name, input half_t exp, input half_t act);
    if (act !== exp) begin
        $display("mismatch %s expected %h actual %h", name, exp, act);
        stop_on_failure();
    end
endtask

task automatic check_addr(input string name, input logic [addr_w-1:0] exp,
                          input logic [addr_w-1:0] act);
    if (act !== exp) begin
        $display("mismatch %s expected %h actual %h", name, exp, act);
        stop_on_failure();
    end
endtask

task automatic check_irq_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("mismatch %s expected %0d actual %0d", name, exp, act);
        stop_on_failure();
    end
endtask

`endif

// ==== dv/csb_tb.sv ====
`default_nettype none

module csb_tb
    import accel_num_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int addr_w      = 32;
    localparam int n_cmds      = 12;
    localparam int stall_worst = 8;   // Cycles allowed per FIFO word
    localparam int unit_worst  = 8;

    typedef struct packed {
        logic [7:0] cmd_idx;
        logic       is_3x3;
        win3_t      im;
        win3_t      iw;
        half_t      ib;
    } win_exp_t;

    typedef struct packed {
        logic [7:0]        cmd_idx;
        logic              last;   // Final write-back of the command
        logic [addr_w-1:0] addr;
    } addr_exp_t;

    logic clk = 1'b0;
    logic arst_n, op_en, cmd_fifo_empty, data_fifo_empty, weight_fifo_empty;
    logic conv_valid_1x1, conv_valid_3x3;
    word_t cmd_word, data_word, weight_word;
    logic cmd_fifo_rd_en, data_fifo_rd_en, weight_fifo_rd_en;
    win1_t im_1x1, iw_1x1;
    win3_t im_3x3, iw_3x3;
    half_t ib_1x1, ib_3x3;
    logic conv_ready_1x1, conv_ready_3x3, dma_aux_re, dma_aux_we, irq;
    logic [addr_w-1:0] r_addr, w_addr;

    word_t     cmd_q[$], data_q[$], wgt_q[$];   // FIFO contents in consume order
    win_exp_t  win_q[$];
    addr_exp_t raddr_q[$], wb_q[$];
    int        exp_irq = 0, irq_cnt = 0, total_words = 0, cycle = 0, limit, unit_delay = 0;
    logic      seen_cmd_rd = 1'b0, unit_wait = 1'b0, nxt_v1 = 1'b0, nxt_v3 = 1'b0;

    always #2 clk = ~clk;

    `include "csb_checks.svh"

    csb #(.addr_w(addr_w)) uut (
        .clk, .arst_n, .op_en, .cmd (cmd_word), .cmd_fifo_empty, .data (data_word),
        .data_fifo_empty, .weightbias (weight_word), .weight_fifo_empty,
        .conv_valid_1x1, .conv_valid_3x3, .cmd_fifo_rd_en, .data_fifo_rd_en,
        .weight_fifo_rd_en, .im_1x1, .iw_1x1, .im_3x3, .iw_3x3, .ib_1x1, .ib_3x3,
        .conv_ready_1x1, .conv_ready_3x3, .dma_aux_re, .dma_aux_we, .r_addr, .w_addr, .irq
    );

    task automatic stop_on_failure();
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic logic [6:0] idle_bits();
        return {data_fifo_rd_en, weight_fifo_rd_en, conv_ready_1x1, conv_ready_3x3,
                dma_aux_re, dma_aux_we, irq};
    endfunction

    task automatic make_window(input int halves, input logic to_data, output win3_t win);
        word_t w;
        win = '0;
        for (int k = 0; k < halves; k += 2) begin
            w = rand_bits(32);
            if (to_data) data_q.push_back(w);
            else wgt_q.push_back(w);
            total_words++;
            win[k] = w[15:0];                            // Low half first
            if (k + 1 < halves) win[k + 1] = w[31:16];   // Odd tail drops the upper half
        end
    endtask

    task automatic build_commands();
        logic [1:0]  sel;
        logic [7:0]  code, stride;
        logic [15:0] in_ch, out_ch;
        word_t       hdr, d_base, wb_base, bias_w;
        win_exp_t    e;
        int          halves;
        for (int c = 0; c < n_cmds; c++) begin
            sel     = 2'(rand_bits(2));
            stride  = 8'(rand_bits(8));
            in_ch   = 16'(rand_bits(2) % 3 + 1);
            out_ch  = 16'(rand_bits(2) % 3 + 1);
            hdr     = rand_bits(32);
            d_base  = rand_bits(32);
            wb_base = rand_bits(32);
            if (c == 2) sel = 2'd0;                           // Keep one bad opcode
            if (c == n_cmds - 1 && sel == 2'd0) sel = 2'd1;   // Run ends on an irq
            code = (sel == 2'd1) ? 8'd1 : 8'd2;
            if (sel == 2'd0) begin
                code = 8'(rand_bits(8));
                if (code == 8'd1 || code == 8'd2) code = code ^ 8'h80;
            end
            hdr[15:0] = {stride, code};
            cmd_q.push_back(hdr);
            cmd_q.push_back({out_ch, in_ch});
            cmd_q.push_back(rand_bits(32));   // weight_addr
            cmd_q.push_back(d_base);
            cmd_q.push_back(wb_base);
            total_words += 5;
            if (sel != 2'd0) begin
                exp_irq++;
                halves = (sel == 2'd1) ? 1 : 9;
                for (int o = 0; o < out_ch; o++) begin
                    bias_w = rand_bits(32);
                    wgt_q.push_back(bias_w);
                    total_words++;
                    for (int i = 0; i < in_ch; i++) begin
                        raddr_q.push_back(addr_exp_t'{8'(c), 1'b0,
                                          addr_w'(d_base + 32'(stride) * i)});
                        e.cmd_idx = 8'(c);
                        e.is_3x3  = (sel != 2'd1);
                        e.ib      = bias_w[15:0];
                        make_window(halves, 1'b1, e.im);
                        make_window(halves, 1'b0, e.iw);
                        win_q.push_back(e);
                    end
                    wb_q.push_back(addr_exp_t'{8'(c), o == out_ch - 1, addr_w'(wb_base + o)});
                end
            end
        end
    endtask

    task automatic check_window();
        win_exp_t e;
        if (win_q.size() == 0) begin
            fail_with("convolution ready raised with no window expected");
        end else begin
            e = win_q[0];
            if (e.is_3x3 != conv_ready_3x3) begin
                fail_with("ready raised toward the wrong convolution unit");
            end else if (e.is_3x3) begin
                check_win3($sformatf("cmd %0d im_3x3", e.cmd_idx), e.im, im_3x3);
                check_win3($sformatf("cmd %0d iw_3x3", e.cmd_idx), e.iw, iw_3x3);
                check_bias($sformatf("cmd %0d ib_3x3", e.cmd_idx), e.ib, ib_3x3);
            end else begin
                check_win1($sformatf("cmd %0d im_1x1", e.cmd_idx), e.im[0], im_1x1);
                check_win1($sformatf("cmd %0d iw_1x1", e.cmd_idx), e.iw[0], iw_1x1);
                check_bias($sformatf("cmd %0d ib_1x1", e.cmd_idx), e.ib, ib_1x1);
            end
        end
    endtask

    // Runs mid-cycle, while every DUT output is settled
    task automatic monitor_cycle();
        addr_exp_t a;
        if (!seen_cmd_rd && idle_bits() !== '0) begin
            fail_with("operand read, ready, strobe or irq seen before the first command");
        end
        if (cmd_fifo_rd_en) begin
            seen_cmd_rd = 1'b1;
            if (cmd_fifo_empty) fail_with("cmd_fifo_rd_en high while the command FIFO is empty");
            else void'(cmd_q.pop_front());
        end
        if (data_fifo_rd_en) begin
            if (data_fifo_empty) fail_with("data_fifo_rd_en high while the data FIFO is empty");
            else void'(data_q.pop_front());
        end
        if (weight_fifo_rd_en) begin
            if (weight_fifo_empty) fail_with("weight_fifo_rd_en high while the weight FIFO is empty");
            else void'(wgt_q.pop_front());
        end
        if (dma_aux_re) begin
            if (raddr_q.size() == 0) begin
                fail_with("dma_aux_re pulsed with no window expected");
            end else begin
                a = raddr_q.pop_front();
                check_addr($sformatf("cmd %0d r_addr", a.cmd_idx), a.addr, r_addr);
            end
        end
        if (dma_aux_we) begin
            if (wb_q.size() == 0) begin
                fail_with("dma_aux_we pulsed with no write-back expected");
            end else begin
                a = wb_q.pop_front();
                check_addr($sformatf("cmd %0d w_addr", a.cmd_idx), a.addr, w_addr);
                check_irq_count($sformatf("cmd %0d irq at write-back", a.cmd_idx),
                                int'(a.last), int'(irq));
            end
        end
        if (irq) irq_cnt++;
        // Convolution unit models
        nxt_v1 = 1'b0;
        nxt_v3 = 1'b0;
        if (conv_ready_1x1 || conv_ready_3x3) begin
            check_window();
            if (conv_valid_1x1 || conv_valid_3x3) begin
                void'(win_q.pop_front());
            end else begin
                if (!unit_wait) begin
                    unit_wait  = 1'b1;
                    unit_delay = int'(rand_bits(3));
                end
                if (unit_delay == 0) begin
                    nxt_v1    = conv_ready_1x1;
                    nxt_v3    = conv_ready_3x3;
                    unit_wait = 1'b0;
                end else begin
                    unit_delay--;
                end
            end
        end
    endtask

    // Heads of the FIFO queues plus random empties
    task automatic drive_inputs();
        cmd_fifo_empty    = (cmd_q.size() == 0) || (rand_bits(2) == 0);
        cmd_word          = (cmd_q.size() != 0) ? cmd_q[0] : '0;
        data_fifo_empty   = (data_q.size() == 0) || (rand_bits(2) == 0);
        data_word         = (data_q.size() != 0) ? data_q[0] : '0;
        weight_fifo_empty = (wgt_q.size() == 0) || (rand_bits(2) == 0);
        weight_word       = (wgt_q.size() != 0) ? wgt_q[0] : '0;
        conv_valid_1x1    = nxt_v1;
        conv_valid_3x3    = nxt_v3;
    endtask

    initial begin
        arst_n            = 1'b0;
        op_en             = 1'b0;
        cmd_word          = '0;
        cmd_fifo_empty    = 1'b1;
        data_word         = '0;
        data_fifo_empty   = 1'b1;
        weight_word       = '0;
        weight_fifo_empty = 1'b1;
        conv_valid_1x1    = 1'b0;
        conv_valid_3x3    = 1'b0;
        build_commands();
        limit = total_words * (stall_worst + unit_worst) + 200;
        repeat (16) begin
            @(negedge clk);
            if ({cmd_fifo_rd_en, idle_bits()} !== '0) begin
                fail_with("control output high during reset");
            end
        end
        @(posedge clk);
        #0.5;
        arst_n = 1'b1;
        op_en  = 1'b1;
        drive_inputs();
        while (!(irq_cnt >= exp_irq && cmd_q.size() == 0)) begin
            @(negedge clk);
            monitor_cycle();
            cycle++;
            if (cycle > limit) begin
                fail_with($sformatf("timeout after %0d cycles without the final irq", limit));
            end
            @(posedge clk);
            #0.5;
            drive_inputs();
        end
        check_irq_count("irq total", exp_irq, irq_cnt);
        if (win_q.size() == 0 && raddr_q.size() == 0 && wb_q.size() == 0 &&
            data_q.size() == 0 && wgt_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            fail_with("windows, strobes or FIFO words left over at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+dv
common/accel_num_pkg.sv
common/accel_cmd_pkg.sv
design/cmd_decoder.sv
design/operand_packer.sv
design/addr_gen.sv
csb/csb_sequencer.sv
csb/csb.sv
dv/csb_tb.sv
